/* project.f */
+incdir+.
dtl_pkg.sv
gm_pkg.sv
dtl_arbiter.sv
dtl_address_isolator.sv
dtl_sram_controller.sv
gm_ram.sv
gm_subsystem.sv
gm_properties.sv
tb_gm_subsystem.sv

/* tb_gm_subsystem.sv */
`timescale 1ns/10ps

`include "gm_defs.svh"

module tb_gm_subsystem;

	localparam int num_ports = `DTL_NUM_PORTS;
	localparam int num_words = 1 << `GM_MEM_ADDR_WIDTH;
	localparam int drive_delay = 10;
	localparam int wait_limit = 200;
	// 400 transactions of at most 20 cycles each
	localparam int watchdog_ns = 400 * 20 * 100;

	// handshake kinds watched by wait_handshake
	localparam int hs_cmd = 0;
	localparam int hs_wr = 1;
	localparam int hs_rd = 2;
	localparam int hs_rd_offer = 3;

	logic clk;
	logic reset;
	logic [num_ports-1:0] cmd_valid;
	dtl_pkg::dtl_cmd_t [num_ports-1:0] cmd;
	logic [num_ports-1:0] cmd_accept;
	logic [num_ports-1:0] wr_valid;
	dtl_pkg::dtl_wr_t [num_ports-1:0] wr;
	logic [num_ports-1:0] wr_accept;
	logic [num_ports-1:0] rd_valid;
	dtl_pkg::dtl_data_t [num_ports-1:0] rd_data;
	logic [num_ports-1:0] rd_accept;

	dtl_pkg::dtl_data_t model [num_words];
	dtl_pkg::dtl_addr_t open_addr [num_ports];
	dtl_pkg::dtl_data_t held_data [num_ports];
	logic [num_ports-1:0] held;
	string test_name;

	gm_subsystem gm_subsystem_inst
	(
		.clk(clk),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.cmd_accept(cmd_accept),
		.wr_valid(wr_valid),
		.wr(wr),
		.wr_accept(wr_accept),
		.rd_valid(rd_valid),
		.rd_data(rd_data),
		.rd_accept(rd_accept)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial
	begin
		#(watchdog_ns);
		fail_run("watchdog expired before all tests completed");
	end

	always @(gm_subsystem_inst.gm_properties_inst.error_count)
	begin
		if (gm_subsystem_inst.gm_properties_inst.error_count != 0)
			fail_run("a bound assertion on the DUT ports failed");
	end

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("TEST FAIL");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic compare_data(input string name, input dtl_pkg::dtl_data_t expected,
		input dtl_pkg::dtl_data_t actual);
		if (actual !== expected)
			fail_run($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
	endtask

	task automatic compare_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			fail_run($sformatf("mismatch %s expected %b actual %b", name, expected, actual));
	endtask

	// ------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------

	function automatic logic in_window(input dtl_pkg::dtl_addr_t addr);
		return (addr >= `GM_RANGE_LOW) && (addr <= `GM_RANGE_HIGH);
	endfunction

	function automatic int word_index(input dtl_pkg::dtl_addr_t addr);
		return int'((addr - `GM_RANGE_LOW) >> 2) % num_words;
	endfunction

	// masked lanes take the new byte and the rest keep the old one
	function automatic dtl_pkg::dtl_data_t merge_bytes(input dtl_pkg::dtl_data_t old_word,
		input dtl_pkg::dtl_mask_t mask, input dtl_pkg::dtl_data_t data);
		dtl_pkg::dtl_data_t result;
		result = old_word;
		for (int b = 0; b < `DTL_DATA_WIDTH/8; b++)
		begin
			if (mask[b])
				result[b*8 +: 8] = data[b*8 +: 8];
		end
		return result;
	endfunction

	function automatic dtl_pkg::dtl_data_t expected_read(input dtl_pkg::dtl_addr_t addr);
		if (in_window(addr))
			return model[word_index(addr)];
		else
			return '0;
	endfunction

	function automatic dtl_pkg::dtl_addr_t word_addr(input int w);
		return `GM_RANGE_LOW + (dtl_pkg::dtl_addr_t'(w) << 2);
	endfunction

	// outputs are settled at the falling edge before the transfer edge
	always @(negedge clk)
	begin
		if (!reset)
		begin
			for (int p = 0; p < num_ports; p++)
			begin
				if (cmd_valid[p] && cmd_accept[p])
					open_addr[p] = cmd[p].addr;
				if (wr_valid[p] && wr_accept[p] && in_window(open_addr[p]))
					model[word_index(open_addr[p])] = merge_bytes(
						model[word_index(open_addr[p])], wr[p].mask, wr[p].data);
				if (held[p])
				begin
					compare_flag({test_name, " rd_valid held"}, 1'b1, rd_valid[p]);
					compare_data({test_name, " rd_data held"}, held_data[p], rd_data[p]);
				end
				if (rd_valid[p] && rd_accept[p])
					compare_data(test_name, expected_read(open_addr[p]), rd_data[p]);
				held[p] = rd_valid[p] && !rd_accept[p];
				held_data[p] = rd_data[p];
			end
		end
	end

	// ------------------------------------------------------------
	// port drivers
	// ------------------------------------------------------------

	task automatic next_drive_point();
		@(posedge clk);
		#drive_delay;
	endtask

	function automatic logic handshake_seen(input int p, input int kind);
		case (kind)
			hs_cmd: return cmd_valid[p] && cmd_accept[p];
			hs_wr: return wr_valid[p] && wr_accept[p];
			hs_rd: return rd_valid[p] && rd_accept[p];
			default: return rd_valid[p];
		endcase
	endfunction

	// returns at the drive point right after the transfer edge
	task automatic wait_handshake(input int p, input int kind, input string what);
		int cycles;
		logic seen;
		cycles = 0;
		seen = 1'b0;
		while (!seen)
		begin
			@(negedge clk);
			seen = handshake_seen(p, kind);
			next_drive_point();
			cycles++;
			if (!seen && cycles > wait_limit)
				fail_run($sformatf("port %0d saw no %s within %0d cycles", p, what, wait_limit));
		end
	endtask

	task automatic write_word(input int p, input dtl_pkg::dtl_addr_t addr,
		input dtl_pkg::dtl_mask_t mask, input dtl_pkg::dtl_data_t data);
		int gap;
		gap = $urandom_range(0, 2);
		cmd[p] = '{addr: addr, read: 1'b0};
		cmd_valid[p] = 1'b1;
		wr[p] = '{mask: mask, data: data};
		wr_valid[p] = (gap == 0);
		wait_handshake(p, hs_cmd, "command accept");
		cmd_valid[p] = 1'b0;
		if (gap != 0)
		begin
			repeat (gap - 1) next_drive_point();
			wr_valid[p] = 1'b1;
		end
		wait_handshake(p, hs_wr, "write accept");
		wr_valid[p] = 1'b0;
	endtask

	// hold_off is the number of cycles rd_valid waits for rd_accept
	task automatic read_word(input int p, input dtl_pkg::dtl_addr_t addr, input int hold_off);
		cmd[p] = '{addr: addr, read: 1'b1};
		cmd_valid[p] = 1'b1;
		rd_accept[p] = (hold_off == 0);
		wait_handshake(p, hs_cmd, "command accept");
		cmd_valid[p] = 1'b0;
		if (hold_off != 0)
		begin
			wait_handshake(p, hs_rd_offer, "read data");
			repeat (hold_off - 1) next_drive_point();
			rd_accept[p] = 1'b1;
		end
		wait_handshake(p, hs_rd, "read accept");
		rd_accept[p] = 1'b0;
	endtask

	// words 0..7 are shared and each port also owns 64 words
	task automatic run_mixed_traffic(input int p);
		dtl_pkg::dtl_addr_t addr;
		for (int n = 0; n < 40; n++)
		begin
			if ($urandom_range(0, 1) == 0)
				addr = word_addr($urandom_range(0, 7));
			else
				addr = word_addr(256 + p * 64 + $urandom_range(0, 63));
			if ($urandom_range(0, 1) == 0)
				write_word(p, addr, $urandom_range(1, 15), $urandom());
			else
				read_word(p, addr, $urandom_range(0, 3));
		end
	endtask

	// ------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------

	initial
	begin
		dtl_pkg::dtl_addr_t addr;
		dtl_pkg::dtl_addr_t alias_addr;
		int w;
		int p;
		void'($urandom(32'heb96_0d83));
		cmd_valid = '0;
		cmd = '0;
		wr_valid = '0;
		wr = '0;
		rd_accept = '0;
		held = '0;
		reset = 1'b1;
		foreach (model[i])
			model[i] = '0;
		test_name = "reset";
		repeat (2) @(posedge clk);
		#drive_delay;
		reset = 1'b0;

		@(negedge clk);
		for (int i = 0; i < num_ports; i++)
		begin
			compare_flag("reset cmd_accept", 1'b0, cmd_accept[i]);
			compare_flag("reset wr_accept", 1'b0, wr_accept[i]);
			compare_flag("reset rd_valid", 1'b0, rd_valid[i]);
		end
		next_drive_point();

		// port 1 must win the first tie after reset
		test_name = "first tie";
		fork
			write_word(0, word_addr(10), 4'hf, $urandom());
			write_word(1, word_addr(11), 4'hf, $urandom());
			begin
				@(negedge clk);
				compare_flag("first tie port 1 accept", 1'b1, cmd_accept[1]);
				compare_flag("first tie port 0 accept", 1'b0, cmd_accept[0]);
			end
		join

		test_name = "full mask write then read";
		for (int n = 0; n < 40; n++)
		begin
			addr = word_addr($urandom_range(0, num_words - 1));
			write_word(0, addr, 4'hf, $urandom());
			read_word(0, addr, $urandom_range(0, 3));
		end

		test_name = "partial mask merge";
		for (int n = 0; n < 30; n++)
		begin
			addr = word_addr($urandom_range(0, 15));
			p = $urandom_range(0, 1);
			write_word(p, addr, $urandom_range(1, 14), $urandom());
			read_word(p, addr, $urandom_range(0, 3));
		end

		test_name = "concurrent ports";
		fork
			run_mixed_traffic(0);
			run_mixed_traffic(1);
		join

		// the first address just above the window aliases word 0
		test_name = "out of window";
		for (int n = 0; n < 10; n++)
		begin
			w = (n == 0) ? 0 : $urandom_range(0, 15);
			alias_addr = word_addr(w);
			if (n == 0)
				addr = `GM_RANGE_HIGH + 1;
			else
				addr = (dtl_pkg::dtl_addr_t'($urandom_range(1, 131071)) << 15) | alias_addr;
			p = $urandom_range(0, 1);
			write_word(p, addr, 4'hf, $urandom());
			read_word(p, addr, $urandom_range(0, 3));
			read_word(p, alias_addr, $urandom_range(0, 3));
		end

		test_name = "read back pressure";
		for (int n = 0; n < 10; n++)
			read_word($urandom_range(0, 1), word_addr($urandom_range(0, 15)), $urandom_range(3, 6));

		repeat (2) next_drive_point();
		$display("TEST PASS");
		$finish;
	end

endmodule

/* gm_properties.sv */
`timescale 1ns/10ps

`include "gm_defs.svh"

module gm_properties
(
	input logic clk,
	input logic reset,
	input logic [`DTL_NUM_PORTS-1:0] cmd_accept,
	input logic [`DTL_NUM_PORTS-1:0] wr_accept,
	input logic [`DTL_NUM_PORTS-1:0] rd_valid,
	input dtl_pkg::dtl_data_t [`DTL_NUM_PORTS-1:0] rd_data,
	input logic [`DTL_NUM_PORTS-1:0] rd_accept
);

	// number of failed assertions so far
	int error_count = 0;

	// the shared path serves one requester at a time
	one_cmd_accept: assert property (@(posedge clk) disable iff (reset) $onehot0(cmd_accept))
		else
		begin
			$error("more than one port saw cmd_accept");
			error_count++;
		end

	quiet_after_reset: assert property (@(posedge clk)
		reset |=> (cmd_accept == '0) && (wr_accept == '0) && (rd_valid == '0))
		else
		begin
			$error("handshake output high in the cycle after reset");
			error_count++;
		end

	// ------------------------------------------------------------
	// read back pressure
	// ------------------------------------------------------------

	for (genvar p = 0; p < `DTL_NUM_PORTS; p++)
	begin : g_port
		rd_held: assert property (@(posedge clk) disable iff (reset)
			rd_valid[p] && !rd_accept[p] |=> rd_valid[p] && $stable(rd_data[p]))
			else
			begin
				$error("port %0d read beat changed before accept", p);
				error_count++;
			end
	end

endmodule

bind gm_subsystem gm_properties gm_properties_inst
(
	.clk(clk),
	.reset(reset),
	.cmd_accept(cmd_accept),
	.wr_accept(wr_accept),
	.rd_valid(rd_valid),
	.rd_data(rd_data),
	.rd_accept(rd_accept)
);

/* gm_subsystem.sv */
`timescale 1ns/10ps

`include "gm_defs.svh"

module gm_subsystem
(
	input logic clk,
	input logic reset,

	// port 0 is the host, port 1 the core
	input logic [`DTL_NUM_PORTS-1:0] cmd_valid,
	input dtl_pkg::dtl_cmd_t [`DTL_NUM_PORTS-1:0] cmd,
	output logic [`DTL_NUM_PORTS-1:0] cmd_accept,
	input logic [`DTL_NUM_PORTS-1:0] wr_valid,
	input dtl_pkg::dtl_wr_t [`DTL_NUM_PORTS-1:0] wr,
	output logic [`DTL_NUM_PORTS-1:0] wr_accept,
	output logic [`DTL_NUM_PORTS-1:0] rd_valid,
	output dtl_pkg::dtl_data_t [`DTL_NUM_PORTS-1:0] rd_data,
	input logic [`DTL_NUM_PORTS-1:0] rd_accept
);

	// ------------------------------------------------------------
	// arbiter to isolator
	// ------------------------------------------------------------

	logic arb_cmd_valid;
	dtl_pkg::dtl_cmd_t arb_cmd;
	logic arb_cmd_accept;
	logic arb_wr_valid;
	dtl_pkg::dtl_wr_t arb_wr;
	logic arb_wr_accept;
	logic arb_rd_valid;
	dtl_pkg::dtl_data_t arb_rd_data;
	logic arb_rd_accept;

	// ------------------------------------------------------------
	// isolator to controller
	// ------------------------------------------------------------

	logic gm_cmd_valid;
	dtl_pkg::dtl_cmd_t gm_cmd;
	logic gm_cmd_accept;
	logic gm_wr_valid;
	dtl_pkg::dtl_wr_t gm_wr;
	logic gm_wr_accept;
	logic gm_rd_valid;
	dtl_pkg::dtl_data_t gm_rd_data;
	logic gm_rd_accept;

	gm_pkg::gm_word_addr_t ram_addr;
	dtl_pkg::dtl_data_t ram_wr_data;
	dtl_pkg::dtl_mask_t ram_wbe;
	dtl_pkg::dtl_data_t ram_rd_data;

	dtl_arbiter dtl_arbiter_inst
	(
		.clk(clk),
		.reset(reset),
		.in_cmd_valid(cmd_valid),
		.in_cmd(cmd),
		.in_cmd_accept(cmd_accept),
		.in_wr_valid(wr_valid),
		.in_wr(wr),
		.in_wr_accept(wr_accept),
		.in_rd_valid(rd_valid),
		.in_rd_data(rd_data),
		.in_rd_accept(rd_accept),
		.out_cmd_valid(arb_cmd_valid),
		.out_cmd(arb_cmd),
		.out_cmd_accept(arb_cmd_accept),
		.out_wr_valid(arb_wr_valid),
		.out_wr(arb_wr),
		.out_wr_accept(arb_wr_accept),
		.out_rd_valid(arb_rd_valid),
		.out_rd_data(arb_rd_data),
		.out_rd_accept(arb_rd_accept)
	);

	dtl_address_isolator
	#(
		.range_low(`GM_RANGE_LOW),
		.range_high(`GM_RANGE_HIGH)
	)
	dtl_address_isolator_inst
	(
		.clk(clk),
		.reset(reset),
		.in_cmd_valid(arb_cmd_valid),
		.in_cmd(arb_cmd),
		.in_cmd_accept(arb_cmd_accept),
		.in_wr_valid(arb_wr_valid),
		.in_wr(arb_wr),
		.in_wr_accept(arb_wr_accept),
		.in_rd_valid(arb_rd_valid),
		.in_rd_data(arb_rd_data),
		.in_rd_accept(arb_rd_accept),
		.out_cmd_valid(gm_cmd_valid),
		.out_cmd(gm_cmd),
		.out_cmd_accept(gm_cmd_accept),
		.out_wr_valid(gm_wr_valid),
		.out_wr(gm_wr),
		.out_wr_accept(gm_wr_accept),
		.out_rd_valid(gm_rd_valid),
		.out_rd_data(gm_rd_data),
		.out_rd_accept(gm_rd_accept)
	);

	dtl_sram_controller dtl_sram_controller_inst
	(
		.clk(clk),
		.reset(reset),
		.cmd_valid(gm_cmd_valid),
		.cmd(gm_cmd),
		.cmd_accept(gm_cmd_accept),
		.wr_valid(gm_wr_valid),
		.wr(gm_wr),
		.wr_accept(gm_wr_accept),
		.rd_valid(gm_rd_valid),
		.rd_data(gm_rd_data),
		.rd_accept(gm_rd_accept),
		.ram_addr(ram_addr),
		.ram_wr_data(ram_wr_data),
		.ram_wbe(ram_wbe),
		.ram_rd_data(ram_rd_data)
	);

	// single address from the controller serves both RAM ports
	gm_ram
	#(
		.addr_width(`GM_MEM_ADDR_WIDTH)
	)
	gm_ram_inst
	(
		.clk(clk),
		.wr_addr(ram_addr),
		.rd_addr(ram_addr),
		.wbe(ram_wbe),
		.wr_data(ram_wr_data),
		.rd_data(ram_rd_data)
	);

endmodule

/* gm_ram.sv */
`timescale 1ns/10ps

`include "gm_defs.svh"

module gm_ram
#(
	parameter int addr_width = `GM_MEM_ADDR_WIDTH
)
(
	input logic clk,
	input logic [addr_width-1:0] wr_addr,
	input logic [addr_width-1:0] rd_addr,
	input dtl_pkg::dtl_mask_t wbe,
	input dtl_pkg::dtl_data_t wr_data,
	output dtl_pkg::dtl_data_t rd_data
);

	localparam int num_bytes = `DTL_DATA_WIDTH/8;
	localparam int depth = 1 << addr_width;

	dtl_pkg::dtl_data_t mem [depth] = '{default: '0};

	// per-lane write, read returns the old word on a collision
	always_ff @(posedge clk)
	begin
		for (int b = 0; b < num_bytes; b++)
		begin
			if (wbe[b])
				mem[wr_addr][b*8 +: 8] <= wr_data[b*8 +: 8];
		end
		rd_data <= mem[rd_addr];
	end

endmodule

/* dtl_sram_controller.sv */
`timescale 1ns/10ps

`include "gm_defs.svh"

module dtl_sram_controller
(
	input logic clk,
	input logic reset,

	// DTL slave
	input logic cmd_valid,
	input dtl_pkg::dtl_cmd_t cmd,
	output logic cmd_accept,
	input logic wr_valid,
	input dtl_pkg::dtl_wr_t wr,
	output logic wr_accept,
	output logic rd_valid,
	output dtl_pkg::dtl_data_t rd_data,
	input logic rd_accept,

	// RAM side
	output gm_pkg::gm_word_addr_t ram_addr,
	output dtl_pkg::dtl_data_t ram_wr_data,
	output dtl_pkg::dtl_mask_t ram_wbe,
	input dtl_pkg::dtl_data_t ram_rd_data
);

	// low address bits select the byte lane
	localparam int byte_sel_w = $clog2(`DTL_DATA_WIDTH/8);

	gm_pkg::gm_ctrl_state_t state;
	gm_pkg::gm_word_addr_t addr_q;
	gm_pkg::gm_word_addr_t cmd_word;
	dtl_pkg::dtl_data_t rd_data_q;

	assign cmd_word = cmd.addr[byte_sel_w +: `GM_MEM_ADDR_WIDTH];

	// ------------------------------------------------------------
	// handshake and RAM drive
	// ------------------------------------------------------------

	assign cmd_accept = (state == gm_pkg::ctrl_idle);
	assign wr_accept = (state == gm_pkg::ctrl_write) & wr_valid;
	assign rd_valid = (state == gm_pkg::ctrl_read_hold);
	assign rd_data = rd_data_q;

	// read address goes straight to the RAM in idle to save a cycle
	assign ram_addr = (state == gm_pkg::ctrl_idle) ? cmd_word : addr_q;
	assign ram_wr_data = wr.data;
	assign ram_wbe = wr_accept ? wr.mask : '0;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= gm_pkg::ctrl_idle;
		end
		else
		begin
			case (state)
				gm_pkg::ctrl_idle:
					if (cmd_valid)
						state <= cmd.read ? gm_pkg::ctrl_read_issue : gm_pkg::ctrl_write;
				gm_pkg::ctrl_write:
					if (wr_valid)
						state <= gm_pkg::ctrl_idle;
				gm_pkg::ctrl_read_issue:
					state <= gm_pkg::ctrl_read_hold;
				gm_pkg::ctrl_read_hold:
					if (rd_accept)
						state <= gm_pkg::ctrl_idle;
				default:
					state <= gm_pkg::ctrl_idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == gm_pkg::ctrl_idle && cmd_valid)
			addr_q <= cmd_word;
		// RAM output is valid one cycle after the address
		if (state == gm_pkg::ctrl_read_issue)
			rd_data_q <= ram_rd_data;
	end

endmodule

/* dtl_address_isolator.sv */
`timescale 1ns/10ps

`include "gm_defs.svh"

module dtl_address_isolator
#(
	parameter dtl_pkg::dtl_addr_t range_low = `GM_RANGE_LOW,
	parameter dtl_pkg::dtl_addr_t range_high = `GM_RANGE_HIGH
)
(
	input logic clk,
	input logic reset,

	// slave side
	input logic in_cmd_valid,
	input dtl_pkg::dtl_cmd_t in_cmd,
	output logic in_cmd_accept,
	input logic in_wr_valid,
	input dtl_pkg::dtl_wr_t in_wr,
	output logic in_wr_accept,
	output logic in_rd_valid,
	output dtl_pkg::dtl_data_t in_rd_data,
	input logic in_rd_accept,

	// master side
	output logic out_cmd_valid,
	output dtl_pkg::dtl_cmd_t out_cmd,
	input logic out_cmd_accept,
	output logic out_wr_valid,
	output dtl_pkg::dtl_wr_t out_wr,
	input logic out_wr_accept,
	input logic out_rd_valid,
	input dtl_pkg::dtl_data_t out_rd_data,
	output logic out_rd_accept
);

	logic in_window;
	logic pend_wr;
	logic pend_rd;
	logic local_busy;
	logic oow_cmd;

	assign in_window = (in_cmd.addr >= range_low) && (in_cmd.addr <= range_high);
	assign local_busy = pend_wr | pend_rd;

	// ------------------------------------------------------------
	// command channel
	// ------------------------------------------------------------

	// downstream sees addresses relative to the window start
	assign out_cmd = '{addr: in_cmd.addr - range_low, read: in_cmd.read};
	assign out_cmd_valid = in_cmd_valid & in_window & ~local_busy;

	assign in_cmd_accept = in_cmd_valid & ~local_busy & (in_window ? out_cmd_accept : 1'b1);
	assign oow_cmd = in_cmd_valid & in_cmd_accept & ~in_window;

	// ------------------------------------------------------------
	// data channels
	// ------------------------------------------------------------

	// out of window writes are swallowed here
	assign out_wr = in_wr;
	assign out_wr_valid = in_wr_valid & ~pend_wr;
	assign in_wr_accept = pend_wr ? in_wr_valid : out_wr_accept;

	// out of window reads return zero
	assign in_rd_valid = pend_rd | out_rd_valid;
	assign in_rd_data = pend_rd ? '0 : out_rd_data;
	assign out_rd_accept = in_rd_accept & ~pend_rd;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pend_wr <= 1'b0;
			pend_rd <= 1'b0;
		end
		else if (oow_cmd)
		begin
			pend_wr <= ~in_cmd.read;
			pend_rd <= in_cmd.read;
		end
		else
		begin
			if (pend_wr && in_wr_valid)
				pend_wr <= 1'b0;
			if (pend_rd && in_rd_accept)
				pend_rd <= 1'b0;
		end
	end

endmodule

/* dtl_arbiter.sv */
`timescale 1ns/10ps

`include "gm_defs.svh"

module dtl_arbiter
(
	input logic clk,
	input logic reset,

	// slave side, one entry per requester
	input logic [`DTL_NUM_PORTS-1:0] in_cmd_valid,
	input dtl_pkg::dtl_cmd_t [`DTL_NUM_PORTS-1:0] in_cmd,
	output logic [`DTL_NUM_PORTS-1:0] in_cmd_accept,
	input logic [`DTL_NUM_PORTS-1:0] in_wr_valid,
	input dtl_pkg::dtl_wr_t [`DTL_NUM_PORTS-1:0] in_wr,
	output logic [`DTL_NUM_PORTS-1:0] in_wr_accept,
	output logic [`DTL_NUM_PORTS-1:0] in_rd_valid,
	output dtl_pkg::dtl_data_t [`DTL_NUM_PORTS-1:0] in_rd_data,
	input logic [`DTL_NUM_PORTS-1:0] in_rd_accept,

	// master side
	output logic out_cmd_valid,
	output dtl_pkg::dtl_cmd_t out_cmd,
	input logic out_cmd_accept,
	output logic out_wr_valid,
	output dtl_pkg::dtl_wr_t out_wr,
	input logic out_wr_accept,
	input logic out_rd_valid,
	input dtl_pkg::dtl_data_t out_rd_data,
	output logic out_rd_accept
);

	localparam int port_w = (`DTL_NUM_PORTS > 1) ? $clog2(`DTL_NUM_PORTS) : 1;

	gm_pkg::arb_state_t state;
	logic [port_w-1:0] grant;
	logic [port_w-1:0] last_served;
	logic grant_read;
	logic [port_w-1:0] winner;
	logic [port_w-1:0] sel;
	logic cmd_done;
	logic xfer_done;

	// round robin, the port right after the last served one has priority
	always_comb
	begin
		int idx;
		winner = last_served;
		for (int i = `DTL_NUM_PORTS; i >= 1; i--)
		begin
			idx = (int'(last_served) + i) % `DTL_NUM_PORTS;
			if (in_cmd_valid[idx])
				winner = idx[port_w-1:0];
		end
	end

	assign sel = (state == gm_pkg::arb_busy) ? grant : winner;

	// ------------------------------------------------------------
	// channel routing
	// ------------------------------------------------------------

	always_comb
	begin
		out_cmd = in_cmd[sel];
		out_wr = in_wr[sel];
		out_cmd_valid = 1'b0;
		out_wr_valid = 1'b0;
		out_rd_accept = 1'b0;
		in_cmd_accept = '0;
		in_wr_accept = '0;
		in_rd_valid = '0;
		if (state == gm_pkg::arb_idle)
		begin
			out_cmd_valid = in_cmd_valid[sel];
			in_cmd_accept[sel] = in_cmd_valid[sel] & out_cmd_accept;
		end
		else
		begin
			// only the channel matching the granted command is opened
			out_wr_valid = in_wr_valid[sel] & ~grant_read;
			in_wr_accept[sel] = out_wr_accept & ~grant_read;
			out_rd_accept = in_rd_accept[sel] & grant_read;
			in_rd_valid[sel] = out_rd_valid & grant_read;
		end
	end

	assign in_rd_data = {`DTL_NUM_PORTS{out_rd_data}};

	assign cmd_done = out_cmd_valid & out_cmd_accept;
	assign xfer_done = (out_wr_valid & out_wr_accept) | (out_rd_valid & out_rd_accept);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= gm_pkg::arb_idle;
			grant <= '0;
			last_served <= '0;
			grant_read <= 1'b0;
		end
		else if (state == gm_pkg::arb_idle)
		begin
			if (cmd_done)
			begin
				state <= gm_pkg::arb_busy;
				grant <= winner;
				last_served <= winner;
				grant_read <= out_cmd.read;
			end
		end
		else if (xfer_done)
		begin
			state <= gm_pkg::arb_idle;
		end
	end

endmodule

/* gm_pkg.sv */
`include "gm_defs.svh"

package gm_pkg;

	// word index into the global memory
	typedef logic [`GM_MEM_ADDR_WIDTH-1:0] gm_word_addr_t;

	// ------------------------------------------------------------
	// state machines
	// ------------------------------------------------------------

	typedef enum logic [1:0]
	{
		ctrl_idle,
		ctrl_write,
		ctrl_read_issue,
		ctrl_read_hold
	} gm_ctrl_state_t;

	typedef enum logic
	{
		arb_idle,
		arb_busy
	} arb_state_t;

endpackage

/* dtl_pkg.sv */
`include "gm_defs.svh"

package dtl_pkg;

	// ------------------------------------------------------------
	// DTL payload types
	// ------------------------------------------------------------

	typedef logic [`DTL_DATA_WIDTH-1:0] dtl_data_t;

	typedef logic [`DTL_ADDR_WIDTH-1:0] dtl_addr_t;

	// one enable per byte lane
	typedef logic [`DTL_DATA_WIDTH/8-1:0] dtl_mask_t;

	// command channel payload, read high for a read
	typedef struct packed
	{
		dtl_addr_t addr;
		logic read;
	} dtl_cmd_t;

	// write channel payload
	typedef struct packed
	{
		dtl_mask_t mask;
		dtl_data_t data;
	} dtl_wr_t;

endpackage

/* gm_defs.svh */
`ifndef GM_DEFS_SVH
`define GM_DEFS_SVH

// ------------------------------------------------------------
// bus widths
// ------------------------------------------------------------

`define DTL_DATA_WIDTH 32

// byte address
`define DTL_ADDR_WIDTH 32

// host and core
`define DTL_NUM_PORTS 2

// ------------------------------------------------------------
// global memory
// ------------------------------------------------------------

// word index, 8192 words
`define GM_MEM_ADDR_WIDTH 13

// byte window decoded by the isolator
`define GM_RANGE_LOW 0
`define GM_RANGE_HIGH 32767

`endif
